//--- elastic_buffer.sv
// Valid/ready FIFO buffer with registered output, used on the request and response paths
`timescale 1ns/1ps

module elastic_buffer #(
    parameter int DATAW = 8,
    parameter int SIZE  = 2
) (
    input  logic             clk,
    input  logic             reset_i,

    input  logic             valid_i,
    output logic             ready_o,
    input  logic [DATAW-1:0] data_i,

    output logic             valid_o,
    input  logic             ready_i,
    output logic [DATAW-1:0] data_o
);
    localparam int ADDRW = (SIZE > 1) ? $clog2(SIZE) : 1;
    localparam int CNTW  = $clog2(SIZE + 1);

    logic [DATAW-1:0] mem [SIZE];
    logic [ADDRW-1:0] wr_ptr;
    logic [ADDRW-1:0] rd_ptr;
    logic [CNTW-1:0]  count;

    logic push;
    logic pop;

    assign ready_o = (count != CNTW'(SIZE));    // Low while full
    assign valid_o = (count != '0);
    assign data_o  = mem[rd_ptr];               // Head entry straight from storage

    assign push = valid_i & ready_o;
    assign pop  = valid_o & ready_i;

    function automatic logic [ADDRW-1:0] next_ptr(input logic [ADDRW-1:0] ptr);
        if (ptr == ADDRW'(SIZE - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= data_i;
        end
    end

endmodule

//--- fp_lane_core.sv
// One FP32 lane of the non-computational FPU: sign injection, classify, move, min/max, compare
`timescale 1ns/1ps

module fp_lane_core
    import fpu_isa_pkg::*;
    import fpu_pipe_pkg::*;
#(
    parameter int LATENCY = 2
) (
    input  logic       clk,
    input  logic       reset_i,
    input  logic       en_i,          // Pipeline advance

    input  logic       in_valid_i,
    input  lane_ctrl_t ctrl_i,
    input  logic       lane_en_i,
    input  fp_word_t   a_i,
    input  fp_word_t   b_i,

    output logic       out_valid_o,
    output fp_word_t   result_o,
    output fflags_t    fflags_o
);
    logic [9:0] cls_a;
    logic [9:0] cls_b;
    logic       a_nan;
    logic       b_nan;
    logic       any_nan;
    logic       any_snan;
    logic       both_zero;
    logic       a_eq_b;
    logic       a_lt_b;

    fp_word_t   res_d;
    fflags_t    flg_d;

    logic     [LATENCY-1:0] vld_q;
    fp_word_t [LATENCY-1:0] res_q;
    fflags_t  [LATENCY-1:0] flg_q;

    // One-hot class of an FP32 value
    function automatic logic [9:0] classify(input fp_word_t x);
        logic [9:0] cls;
        logic       exp_ones;
        logic       exp_zero;
        logic       man_zero;
        cls      = '0;
        exp_ones = &x[30:23];
        exp_zero = ~|x[30:23];
        man_zero = ~|x[22:0];
        if (exp_ones) begin
            if (man_zero) begin
                cls[x[31] ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
            end else if (x[22]) begin
                cls[CLASS_QNAN] = 1'b1;    // Quiet bit set
            end else begin
                cls[CLASS_SNAN] = 1'b1;
            end
        end else if (exp_zero) begin
            if (man_zero) begin
                cls[x[31] ? CLASS_NEG_ZERO : CLASS_POS_ZERO] = 1'b1;
            end else begin
                cls[x[31] ? CLASS_NEG_SUBNORM : CLASS_POS_SUBNORM] = 1'b1;
            end
        end else begin
            cls[x[31] ? CLASS_NEG_NORM : CLASS_POS_NORM] = 1'b1;
        end
        return cls;
    endfunction

    assign cls_a     = classify(a_i);
    assign cls_b     = classify(b_i);
    assign a_nan     = cls_a[CLASS_SNAN] | cls_a[CLASS_QNAN];
    assign b_nan     = cls_b[CLASS_SNAN] | cls_b[CLASS_QNAN];
    assign any_nan   = a_nan | b_nan;
    assign any_snan  = cls_a[CLASS_SNAN] | cls_b[CLASS_SNAN];
    assign both_zero = (a_i[30:0] == '0) && (b_i[30:0] == '0);
    assign a_eq_b    = (a_i == b_i) | both_zero;    // +0 equals -0

    // Total order on non-NaN values, -0 below +0
    always_comb begin
        if (a_i[31] != b_i[31]) begin
            a_lt_b = a_i[31];
        end else if (a_i[31]) begin
            a_lt_b = b_i[30:0] < a_i[30:0];    // Both negative
        end else begin
            a_lt_b = a_i[30:0] < b_i[30:0];
        end
    end

    always_comb begin
        res_d = '0;
        flg_d = '0;
        case (ctrl_i.core_op)
            SGNJ: begin
                case (ctrl_i.variant)
                    SGNJ_NB: res_d = {~b_i[31], a_i[30:0]};
                    SGNJ_X:  res_d = {a_i[31] ^ b_i[31], a_i[30:0]};
                    default: res_d = {b_i[31], a_i[30:0]};
                endcase
            end
            CLASS: res_d = {{(FLEN-10){1'b0}}, cls_a};
            MOVE:  res_d = a_i;                           // Raw bit copy
            MINMAX: begin
                if (a_nan && b_nan) begin
                    res_d = CANON_NAN;
                end else if (a_nan) begin
                    res_d = b_i;
                end else if (b_nan) begin
                    res_d = a_i;
                end else if (ctrl_i.variant == MM_MAX) begin
                    res_d = a_lt_b ? b_i : a_i;
                end else begin
                    res_d = a_lt_b ? a_i : b_i;
                end
                flg_d.nv = any_snan;
            end
            CMP: begin
                case (ctrl_i.variant)
                    CMP_LT: begin
                        res_d[0] = ~any_nan & a_lt_b & ~both_zero;
                        flg_d.nv = any_nan;              // Signaling compare
                    end
                    CMP_LE: begin
                        res_d[0] = ~any_nan & (a_lt_b | a_eq_b);
                        flg_d.nv = any_nan;
                    end
                    default: begin
                        res_d[0] = ~any_nan & a_eq_b;
                        flg_d.nv = any_snan;             // Quiet compare
                    end
                endcase
            end
            default: ;
        endcase
        if (!lane_en_i) begin
            res_d = '0;
            flg_d = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vld_q <= '0;
        end else if (en_i) begin
            vld_q[0] <= in_valid_i;
            for (int s = 1; s < LATENCY; s++) begin
                vld_q[s] <= vld_q[s-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (en_i) begin
            res_q[0] <= res_d;
            flg_q[0] <= flg_d;
            for (int s = 1; s < LATENCY; s++) begin
                res_q[s] <= res_q[s-1];
                flg_q[s] <= flg_q[s-1];
            end
        end
    end

    assign out_valid_o = vld_q[LATENCY-1];
    assign result_o    = res_q[LATENCY-1];
    assign fflags_o    = flg_q[LATENCY-1];

endmodule

//--- fpu_chk.sv
// Handshake assertions on the FPU response port, bound into fpu_top by the testbench
`timescale 1ns/1ps

module fpu_chk
    import fpu_isa_pkg::*;
#(
    parameter int NUM_LANES = 4,
    parameter int TAG_WIDTH = 6
) (
    input logic                     clk,
    input logic                     reset_i,
    input logic                     rsp_valid_o,
    input logic                     rsp_ready_i,
    input fp_word_t [NUM_LANES-1:0] result_o,
    input logic                     has_fflags_o,
    input fflags_t                  fflags_o,
    input logic     [TAG_WIDTH-1:0] tag_o
);
    // Stalled response must hold
    a_rsp_stable: assert property (@(posedge clk) disable iff (reset_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(result_o)
            && $stable(has_fflags_o) && $stable(fflags_o) && $stable(tag_o))
        else $error("response changed while stalled");

    a_valid_known: assert property (@(posedge clk) disable iff (reset_i)
        !$isunknown(rsp_valid_o))
        else $error("rsp_valid_o is unknown");

    a_idle_after_reset: assert property (@(posedge clk)
        $fell(reset_i) |-> !rsp_valid_o)
        else $error("rsp_valid_o high right after reset");
endmodule

//--- fpu_isa_pkg.sv
// Instruction-level FP32 encodings shared by the FPU design and its testbench
package fpu_isa_pkg;

    localparam int FLEN = 32;    // Operand width

    typedef logic [FLEN-1:0] fp_word_t;

    // Opcode group, as seen by the FPU issue port
    typedef enum logic [1:0] {
        FPU_CMP  = 2'b00,
        FPU_MISC = 2'b01
    } fpu_grp_e;

    typedef logic [2:0] fpu_sub_t;    // Sub-operation, carried in the frm field

    // Sub-operations under FPU_CMP
    localparam fpu_sub_t SUB_FLE     = 3'd0;
    localparam fpu_sub_t SUB_FLT     = 3'd1;
    localparam fpu_sub_t SUB_FEQ     = 3'd2;

    // Sub-operations under FPU_MISC
    localparam fpu_sub_t SUB_FSGNJ   = 3'd0;
    localparam fpu_sub_t SUB_FSGNJN  = 3'd1;
    localparam fpu_sub_t SUB_FSGNJX  = 3'd2;
    localparam fpu_sub_t SUB_FCLASS  = 3'd3;
    localparam fpu_sub_t SUB_FMV_X_W = 3'd4;
    localparam fpu_sub_t SUB_FMV_W_X = 3'd5;
    localparam fpu_sub_t SUB_FMIN    = 3'd6;
    localparam fpu_sub_t SUB_FMAX    = 3'd7;

    typedef struct packed {
        fpu_grp_e grp;
        fpu_sub_t sub;
    } fpu_req_t;

    // Same bit order as the RISC-V fflags CSR
    typedef struct packed {
        logic nv;    // Invalid operation
        logic dz;    // Divide by zero
        logic of;    // Overflow
        logic uf;    // Underflow
        logic nx;    // Inexact
    } fflags_t;

    // Bit positions of the FCLASS result
    localparam int CLASS_NEG_INF     = 0;
    localparam int CLASS_NEG_NORM    = 1;
    localparam int CLASS_NEG_SUBNORM = 2;
    localparam int CLASS_NEG_ZERO    = 3;
    localparam int CLASS_POS_ZERO    = 4;
    localparam int CLASS_POS_SUBNORM = 5;
    localparam int CLASS_POS_NORM    = 6;
    localparam int CLASS_POS_INF     = 7;
    localparam int CLASS_SNAN        = 8;
    localparam int CLASS_QNAN        = 9;

endpackage

//--- fpu_nc.f
fpu_isa_pkg.sv
fpu_pipe_pkg.sv
elastic_buffer.sv
fp_lane_core.sv
fpu_noncomp_unit.sv
fpu_top.sv
tb_clk_gen.sv
fpu_chk.sv
fpu_tb.sv

//--- fpu_noncomp_unit.sv
// Non-computational FPU unit: decodes requests, runs one lane core per lane, buffers responses
`timescale 1ns/1ps

module fpu_noncomp_unit
    import fpu_isa_pkg::*;
    import fpu_pipe_pkg::*;
#(
    parameter int NUM_LANES    = 4,
    parameter int TAG_WIDTH    = 6,
    parameter int LATENCY      = 2,
    parameter int RSP_BUF_SIZE = 2
) (
    input  logic                           clk,
    input  logic                           reset_i,

    input  logic                           valid_i,
    output logic                           ready_o,
    input  fpu_req_t                       req_i,
    input  logic     [NUM_LANES-1:0]       mask_i,
    input  logic     [TAG_WIDTH-1:0]       tag_i,
    input  fp_word_t [NUM_LANES-1:0]       dataa_i,
    input  fp_word_t [NUM_LANES-1:0]       datab_i,

    output logic                           valid_o,
    input  logic                           ready_i,
    output fp_word_t [NUM_LANES-1:0]       result_o,
    output logic                           has_fflags_o,
    output fflags_t                        fflags_o,
    output logic     [TAG_WIDTH-1:0]       tag_o
);
    localparam int RSP_DATAW = NUM_LANES * (FLEN + $bits(fflags_t)) + 1 + TAG_WIDTH;

    lane_ctrl_t ctrl;
    logic       pipe_en;
    logic       rsp_ready;

    logic     [NUM_LANES-1:0] lane_valid;
    fp_word_t [NUM_LANES-1:0] lane_result;
    fflags_t  [NUM_LANES-1:0] lane_flags;
    fflags_t  [NUM_LANES-1:0] buf_flags;
    fflags_t                  merged_flags;

    logic [LATENCY-1:0][TAG_WIDTH-1:0] tag_q;
    logic [LATENCY-1:0]                hf_q;

    always_comb begin
        ctrl = '{core_op: MOVE, variant: 2'd0, has_fflags: 1'b0};
        case (req_i.grp)
            FPU_CMP: begin
                ctrl.core_op    = CMP;
                ctrl.has_fflags = 1'b1;
                case (req_i.sub)
                    SUB_FLT: ctrl.variant = CMP_LT;
                    SUB_FEQ: ctrl.variant = CMP_EQ;
                    default: ctrl.variant = CMP_LE;
                endcase
            end
            FPU_MISC: begin
                case (req_i.sub)
                    SUB_FSGNJ:  ctrl = '{core_op: SGNJ, variant: SGNJ_B, has_fflags: 1'b0};
                    SUB_FSGNJN: ctrl = '{core_op: SGNJ, variant: SGNJ_NB, has_fflags: 1'b0};
                    SUB_FSGNJX: ctrl = '{core_op: SGNJ, variant: SGNJ_X, has_fflags: 1'b0};
                    SUB_FCLASS: ctrl.core_op = CLASS;
                    SUB_FMIN:   ctrl = '{core_op: MINMAX, variant: MM_MIN, has_fflags: 1'b1};
                    SUB_FMAX:   ctrl = '{core_op: MINMAX, variant: MM_MAX, has_fflags: 1'b1};
                    default:    ctrl.core_op = MOVE;    // FMV.X.W and FMV.W.X
                endcase
            end
            default: ;
        endcase
    end

    // Shared stall: advance when the last stage drains or is empty
    assign pipe_en = ~lane_valid[0] | rsp_ready;
    assign ready_o = pipe_en;

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lanes
        fp_lane_core #(
            .LATENCY (LATENCY)
        ) lane (
            .clk         (clk),
            .reset_i     (reset_i),
            .en_i        (pipe_en),
            .in_valid_i  (valid_i),
            .ctrl_i      (ctrl),
            .lane_en_i   (mask_i[i]),
            .a_i         (dataa_i[i]),
            .b_i         (datab_i[i]),
            .out_valid_o (lane_valid[i]),
            .result_o    (lane_result[i]),
            .fflags_o    (lane_flags[i])
        );
    end

    // Tag and flag-valid ride alongside the lanes
    always_ff @(posedge clk) begin
        if (pipe_en) begin
            tag_q[0] <= tag_i;
            hf_q[0]  <= ctrl.has_fflags;
            for (int s = 1; s < LATENCY; s++) begin
                tag_q[s] <= tag_q[s-1];
                hf_q[s]  <= hf_q[s-1];
            end
        end
    end

    elastic_buffer #(
        .DATAW (RSP_DATAW),
        .SIZE  (RSP_BUF_SIZE)
    ) rsp_buf (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (lane_valid[0]),    // All lanes move in step
        .ready_o (rsp_ready),
        .data_i  ({lane_result, lane_flags, hf_q[LATENCY-1], tag_q[LATENCY-1]}),
        .valid_o (valid_o),
        .ready_i (ready_i),
        .data_o  ({result_o, buf_flags, has_fflags_o, tag_o})
    );

    // Masked lanes already report zero flags
    always_comb begin
        merged_flags = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            merged_flags = merged_flags | buf_flags[i];
        end
    end

    assign fflags_o = merged_flags;

endmodule

//--- fpu_pipe_pkg.sv
// Internal datapath types for the decoded control that travels down the lane pipelines
package fpu_pipe_pkg;

    // Core operation after decode
    typedef enum logic [2:0] {
        SGNJ   = 3'd0,
        CLASS  = 3'd1,
        MOVE   = 3'd2,
        MINMAX = 3'd3,
        CMP    = 3'd4
    } core_op_e;

    // Variant values for SGNJ
    localparam logic [1:0] SGNJ_B  = 2'd0;    // Sign of b
    localparam logic [1:0] SGNJ_NB = 2'd1;    // Inverted sign of b
    localparam logic [1:0] SGNJ_X  = 2'd2;    // XOR of both signs

    // Variant values for MINMAX
    localparam logic [1:0] MM_MIN  = 2'd0;
    localparam logic [1:0] MM_MAX  = 2'd1;

    // Variant values for CMP
    localparam logic [1:0] CMP_LE  = 2'd0;
    localparam logic [1:0] CMP_LT  = 2'd1;
    localparam logic [1:0] CMP_EQ  = 2'd2;

    typedef struct packed {
        core_op_e   core_op;
        logic [1:0] variant;
        logic       has_fflags;    // Flags carry meaning for this op
    } lane_ctrl_t;

    localparam logic [31:0] CANON_NAN = 32'h7fc00000;

endpackage

//--- fpu_tb.sv
// Directed testbench for fpu_top with a reference model, in-order response checks and a timeout
`timescale 1ns/1ps

module fpu_tb
    import fpu_isa_pkg::*;
;
    localparam int NL            = 4;
    localparam int TW            = 6;
    localparam int DIRECTED_REQS = 23;
    localparam int STREAM_REQS   = 200;
    localparam int CYCLE_LIMIT   = 8 * (DIRECTED_REQS + STREAM_REQS) + 200;

    localparam fp_word_t PZ = 32'h00000000, NZ = 32'h80000000;
    localparam fp_word_t P1 = 32'h3f800000, N1 = 32'hbf800000;
    localparam fp_word_t P2 = 32'h40000000, N2 = 32'hc0000000;
    localparam fp_word_t QN = 32'h7fc00000, SN = 32'h7f800001;
    localparam fp_word_t PI = 32'h7f800000, NI = 32'hff800000;
    localparam fp_word_t PS = 32'h00000001, NS = 32'h80000001;

    typedef struct packed {
        fp_word_t [NL-1:0] result;
        fflags_t           flags;
        logic              hf;
        logic [TW-1:0]     tag;
    } rsp_t;

    logic clk, reset;
    logic req_valid, req_ready, rsp_valid, rsp_ready, has_fflags;
    fpu_req_t req;
    logic [NL-1:0] mask;
    logic [TW-1:0] tag, tag_out;
    fp_word_t [NL-1:0] dataa, datab, result;
    fflags_t fflags;

    rsp_t exp_q[$];
    int sent, checked, cycles, err_count;
    logic [TW-1:0] next_tag;
    int ready_mode;    // 0 ready, 1 hold low, 2 random
    logic saw_req_stall;

    tb_clk_gen clk_gen (.clk_o(clk), .reset_o(reset));

    fpu_top #(.NUM_LANES(NL), .TAG_WIDTH(TW)) dut_i (
        .clk(clk), .reset_i(reset),
        .req_valid_i(req_valid), .req_ready_o(req_ready), .req_i(req),
        .mask_i(mask), .tag_i(tag), .dataa_i(dataa), .datab_i(datab),
        .rsp_valid_o(rsp_valid), .rsp_ready_i(rsp_ready), .result_o(result),
        .has_fflags_o(has_fflags), .fflags_o(fflags), .tag_o(tag_out)
    );

    bind fpu_top fpu_chk #(.NUM_LANES(NUM_LANES), .TAG_WIDTH(TAG_WIDTH)) chk_i (
        .clk(clk), .reset_i(reset_i), .rsp_valid_o(rsp_valid_o),
        .rsp_ready_i(rsp_ready_i), .result_o(result_o), .has_fflags_o(has_fflags_o),
        .fflags_o(fflags_o), .tag_o(tag_o)
    );

    function automatic int class_index(input fp_word_t x);
        logic neg;
        neg = x[31];
        if (x[30:23] == 8'hff && x[22:0] != 0) return x[22] ? CLASS_QNAN : CLASS_SNAN;
        if (x[30:23] == 8'hff) return neg ? CLASS_NEG_INF : CLASS_POS_INF;
        if (x[30:23] != 0) return neg ? CLASS_NEG_NORM : CLASS_POS_NORM;
        if (x[22:0] != 0) return neg ? CLASS_NEG_SUBNORM : CLASS_POS_SUBNORM;
        return neg ? CLASS_NEG_ZERO : CLASS_POS_ZERO;
    endfunction

    // Signed ordering key that maps both zeros to 0
    function automatic logic signed [32:0] order_key(input fp_word_t x);
        logic signed [32:0] mag;
        mag = {2'b00, x[30:0]};
        return x[31] ? -mag : mag;
    endfunction

    function automatic void model_lane(input fpu_req_t r, input logic en, input fp_word_t a,
                                       input fp_word_t b, output fp_word_t res,
                                       output fflags_t f);
        logic a_nan, b_nan, snan, lt, eq;
        a_nan = class_index(a) >= CLASS_SNAN;
        b_nan = class_index(b) >= CLASS_SNAN;
        snan  = class_index(a) == CLASS_SNAN || class_index(b) == CLASS_SNAN;
        lt    = order_key(a) < order_key(b);
        eq    = order_key(a) == order_key(b);
        res   = '0;
        f     = '0;
        if (r.grp == FPU_CMP) begin
            if (r.sub == SUB_FEQ) f.nv = snan;
            else f.nv = a_nan | b_nan;
            if (!(a_nan || b_nan)) begin
                if (r.sub == SUB_FEQ) res = 32'(eq);
                else if (r.sub == SUB_FLT) res = 32'(lt);
                else res = 32'(lt | eq);
            end
        end else if (r.sub <= SUB_FSGNJX) begin
            res = a;
            if (r.sub == SUB_FSGNJ) res[31] = b[31];
            if (r.sub == SUB_FSGNJN) res[31] = !b[31];
            if (r.sub == SUB_FSGNJX) res[31] = a[31] ^ b[31];
        end else if (r.sub == SUB_FCLASS) begin
            res[class_index(a)] = 1'b1;
        end else if (r.sub == SUB_FMIN || r.sub == SUB_FMAX) begin
            f.nv = snan;
            if (a_nan && b_nan) res = 32'h7fc00000;
            else if (a_nan) res = b;
            else if (b_nan) res = a;
            else if (eq && a[30:0] == 0)    // -0 is the smaller of two signed zeros
                res = ((r.sub == SUB_FMIN) == a[31]) ? a : b;
            else if (r.sub == SUB_FMIN) res = lt ? a : b;
            else res = lt ? b : a;
        end else begin
            res = a;
        end
        if (!en) begin
            res = '0;
            f   = '0;
        end
    endfunction

    task automatic fail_now(input string what);
        err_count++;
        $display("%s", what);
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic check_result(input fp_word_t [NL-1:0] got, input fp_word_t [NL-1:0] exp);
        for (int i = 0; i < NL; i++) begin
            if (got[i] !== exp[i])
                fail_now($sformatf("[FAIL] result_o[%0d] got %h expected %h", i, got[i], exp[i]));
        end
    endtask

    task automatic check_flags(input fflags_t got, input fflags_t exp, input logic hf_got,
                               input logic hf_exp);
        if (hf_got !== hf_exp)
            fail_now($sformatf("[FAIL] has_fflags_o got %h expected %h", hf_got, hf_exp));
        if (got !== exp)
            fail_now($sformatf("[FAIL] fflags_o got %h expected %h", got, exp));
    endtask

    task automatic check_tag(input logic [TW-1:0] got, input logic [TW-1:0] exp);
        if (got !== exp)
            fail_now($sformatf("[FAIL] tag_o got %h expected %h", got, exp));
    endtask

    // Drive one request on the falling edge and queue its expected response
    task automatic send(input fpu_grp_e grp, input fpu_sub_t sub, input logic [NL-1:0] m,
                        input fp_word_t [NL-1:0] a, input fp_word_t [NL-1:0] b);
        rsp_t e;
        fpu_req_t r;
        r = '{grp: grp, sub: sub};
        e = '0;
        e.tag = next_tag;
        e.hf  = (grp == FPU_CMP) || sub == SUB_FMIN || sub == SUB_FMAX;
        for (int i = 0; i < NL; i++) begin
            fflags_t lf;
            model_lane(r, m[i], a[i], b[i], e.result[i], lf);
            e.flags = e.flags | lf;
        end
        req   = r;
        mask  = m;
        tag   = next_tag;
        dataa = a;
        datab = b;
        req_valid = 1'b1;
        exp_q.push_back(e);
        while (!req_ready) @(negedge clk);
        @(negedge clk);    // Accepted on the edge in between
        req_valid = 1'b0;
        next_tag++;
        sent++;
    endtask

    task automatic wait_drain();
        while (checked != sent) @(negedge clk);
    endtask

    task automatic sign_inject_and_moves();
        for (int s = 0; s < 6; s++) begin
            if (s == 3) continue;
            send(FPU_MISC, 3'(s), 4'hf, {P1, N2, NZ, SN}, {N1, N1, PZ, QN});
        end
    endtask

    task automatic classify_each_class();
        send(FPU_MISC, SUB_FCLASS, 4'hf, {NI, N1, NS, NZ}, '0);
        send(FPU_MISC, SUB_FCLASS, 4'hf, {PZ, PS, P1, PI}, '0);
        send(FPU_MISC, SUB_FCLASS, 4'hf, {SN, QN, 32'hffc00001, 32'hff800001}, '0);
    endtask

    task automatic compare_ops();
        for (int s = 0; s < 3; s++) begin
            send(FPU_CMP, 3'(s), 4'hf, {P1, N2, NZ, P2}, {P2, N1, PZ, P2});
            send(FPU_CMP, 3'(s), 4'hf, {QN, P1, SN, QN}, {P1, SN, SN, QN});
            // Quiet NaNs alone leave nv clear for FEQ only
            send(FPU_CMP, 3'(s), 4'hf, {QN, P1, 32'hffc00000, QN}, {P2, QN, N1, QN});
        end
    endtask

    task automatic min_max_ops();
        send(FPU_MISC, SUB_FMIN, 4'hf, {NZ, PZ, QN, N1}, {PZ, NZ, P2, N2});
        send(FPU_MISC, SUB_FMAX, 4'hf, {NZ, PZ, P2, N1}, {PZ, NZ, QN, N2});
        send(FPU_MISC, SUB_FMIN, 4'hf, {QN, SN, QN, P1}, {QN, QN, SN, SN});
        send(FPU_MISC, SUB_FMAX, 4'hf, {QN, SN, QN, P1}, {QN, QN, SN, SN});
    endtask

    task automatic masked_lanes();
        send(FPU_CMP, SUB_FEQ, 4'b0101, {SN, P1, SN, P1}, {P1, P1, P1, P1});
        send(FPU_MISC, SUB_FMAX, 4'b1010, {P1, SN, P1, SN}, {P2, P2, P2, P2});
    endtask

    function automatic fp_word_t pick_value();
        fp_word_t pool[12] = '{PZ, NZ, P1, N1, P2, N2, QN, SN, PI, NI, PS, NS};
        if ($urandom % 2 == 0) return pool[$urandom % 12];
        return $urandom;
    endfunction

    task automatic random_stream();
        ready_mode = 1;
        fork
            for (int n = 0; n < STREAM_REQS; n++) begin
                fp_word_t [NL-1:0] a, b;
                fpu_grp_e g;
                fpu_sub_t s;
                for (int i = 0; i < NL; i++) begin
                    a[i] = pick_value();
                    b[i] = pick_value();
                end
                g = ($urandom % 2) ? FPU_MISC : FPU_CMP;
                s = (g == FPU_CMP) ? 3'($urandom % 3) : 3'($urandom % 8);
                send(g, s, 4'($urandom), a, b);
            end
            begin
                repeat (20) @(negedge clk);
                if (!saw_req_stall) fail_now("req_ready_o never fell while responses stalled");
                ready_mode = 2;
            end
        join
        wait_drain();
        ready_mode = 0;
    endtask

    always @(negedge clk) begin
        if (ready_mode == 1 && !req_ready) saw_req_stall = 1'b1;
        case (ready_mode)
            1: rsp_ready = 1'b0;
            2: rsp_ready = 1'($urandom % 2);
            default: rsp_ready = 1'b1;
        endcase
    end

    // Response monitor that pops expected results in request order
    always @(posedge clk) begin
        if (!reset && rsp_valid && rsp_ready) begin
            rsp_t e;
            if (exp_q.size() == 0) begin
                fail_now("response arrived with no request outstanding");
            end else begin
                e = exp_q.pop_front();
                check_tag(tag_out, e.tag);
                check_result(result, e.result);
                check_flags(fflags, e.flags, has_fflags, e.hf);
                checked++;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout after %0d cycles, %0d of %0d responses seen", cycles, checked, sent);
            $display("Checks failed");
            $fatal(1);
        end
    end

    initial begin
        void'($urandom(32'hf2dbcf2d));
        req_valid = 1'b0;
        req = '0;
        mask = '0;
        tag = '0;
        dataa = '0;
        datab = '0;
        rsp_ready = 1'b1;
        ready_mode = 0;
        saw_req_stall = 1'b0;
        next_tag = '0;
        sent = 0;
        checked = 0;
        cycles = 0;
        err_count = 0;
        @(negedge reset);
        @(negedge clk);
        if (!req_ready || rsp_valid) fail_now("port state after reset is wrong");
        sign_inject_and_moves();
        classify_each_class();
        compare_ops();
        min_max_ops();
        masked_lanes();
        wait_drain();
        random_stream();
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end
endmodule

//--- fpu_top.sv
// FPU non-computational top level, a request buffer in front of the lane unit
`timescale 1ns/1ps

module fpu_top
    import fpu_isa_pkg::*;
#(
    parameter int NUM_LANES    = 4,
    parameter int TAG_WIDTH    = 6,
    parameter int LATENCY      = 2,
    parameter int REQ_BUF_SIZE = 2,
    parameter int RSP_BUF_SIZE = 2
) (
    input  logic                     clk,
    input  logic                     reset_i,

    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  fpu_req_t                 req_i,
    input  logic     [NUM_LANES-1:0] mask_i,
    input  logic     [TAG_WIDTH-1:0] tag_i,
    input  fp_word_t [NUM_LANES-1:0] dataa_i,
    input  fp_word_t [NUM_LANES-1:0] datab_i,

    output logic                     rsp_valid_o,
    input  logic                     rsp_ready_i,
    output fp_word_t [NUM_LANES-1:0] result_o,
    output logic                     has_fflags_o,
    output fflags_t                  fflags_o,
    output logic     [TAG_WIDTH-1:0] tag_o
);
    localparam int REQ_DATAW = $bits(fpu_req_t) + NUM_LANES + TAG_WIDTH + 2 * NUM_LANES * FLEN;

    logic                     unit_valid;
    logic                     unit_ready;
    fpu_req_t                 unit_req;
    logic     [NUM_LANES-1:0] unit_mask;
    logic     [TAG_WIDTH-1:0] unit_tag;
    fp_word_t [NUM_LANES-1:0] unit_dataa;
    fp_word_t [NUM_LANES-1:0] unit_datab;

    elastic_buffer #(
        .DATAW (REQ_DATAW),
        .SIZE  (REQ_BUF_SIZE)
    ) req_buf (
        .clk     (clk),
        .reset_i (reset_i),
        .valid_i (req_valid_i),
        .ready_o (req_ready_o),
        .data_i  ({req_i, mask_i, tag_i, dataa_i, datab_i}),
        .valid_o (unit_valid),
        .ready_i (unit_ready),
        .data_o  ({unit_req, unit_mask, unit_tag, unit_dataa, unit_datab})
    );

    fpu_noncomp_unit #(
        .NUM_LANES    (NUM_LANES),
        .TAG_WIDTH    (TAG_WIDTH),
        .LATENCY      (LATENCY),
        .RSP_BUF_SIZE (RSP_BUF_SIZE)
    ) noncomp (
        .clk          (clk),
        .reset_i      (reset_i),
        .valid_i      (unit_valid),
        .ready_o      (unit_ready),
        .req_i        (unit_req),
        .mask_i       (unit_mask),
        .tag_i        (unit_tag),
        .dataa_i      (unit_dataa),
        .datab_i      (unit_datab),
        .valid_o      (rsp_valid_o),
        .ready_i      (rsp_ready_i),
        .result_o     (result_o),
        .has_fflags_o (has_fflags_o),
        .fflags_o     (fflags_o),
        .tag_o        (tag_o)
    );

endmodule

//--- run.sh
#!/usr/bin/env bash
# Build and run the FPU testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module fpu_tb -f fpu_nc.f -o fpu_sim &&
    ./obj_dir/fpu_sim > sim.log 2>&1

grep -qx "All checks passed" sim.log && echo "PASS" || {
    echo "FAIL, see sim.log"
    exit 1
}

//--- tb_clk_gen.sv
// Testbench clock and reset source, 10 ns period with reset held for 3 cycles
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o = 1'b0;
        forever #5 clk_o = ~clk_o;
    end

    initial begin
        reset_o = 1'b1;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        reset_o = 1'b0;    // Released away from the active edge
    end
endmodule
